//--- frame_format_pkg.sv
// header values fixed per card type; layout assumes 5 command bytes, no byte shared with type
package frame_format_pkg;

   // ========================================
   // fixed header and type values
   // ========================================

   // destination is always the master station
   localparam logic [7:0] dest_addr_byte = 8'hFE;
   localparam logic [7:0] func_code_byte = 8'h20;
   // card type byte, written at offs_type
   localparam logic [7:0] type_byte = 8'h60;

   // request mode codes
   localparam logic [7:0] mode_download = 8'h02;

   // station address rule, addr = rack * span + span - slot
   localparam int slots_per_rack = 14;

   // ========================================
   // frame layout, byte offsets in buffer
   // ========================================

   // offsets 0..2 carry dest, src, func
   localparam int offs_mode = 3;
   localparam int offs_cmd = 4;
   localparam int cmd_len = 5;
   localparam int offs_type = 9;
   localparam int offs_data = 10;
   localparam int data_len = 128;
   localparam int frame_len = 138;
   // download data starts this far past the request address
   localparam int download_data_skip = 8;

   // ========================================
   // assembler sequence states
   // ========================================

   localparam int st_w = 3;
   localparam logic [st_w-1:0] st_idle = 3'd0;
   localparam logic [st_w-1:0] st_header = 3'd1;
   localparam logic [st_w-1:0] st_wait_request = 3'd2;
   localparam logic [st_w-1:0] st_mode = 3'd3;
   localparam logic [st_w-1:0] st_command = 3'd4;
   localparam logic [st_w-1:0] st_type = 3'd5;
   localparam logic [st_w-1:0] st_data = 3'd6;

endpackage

//--- mem_bus_pkg.sv
// all three source memories share one address width and one fixed latency, latency must be >= 2
package mem_bus_pkg;

   // ========================================
   // bus widths
   // ========================================

   localparam int mem_addr_w = 24;
   localparam int buf_addr_w = 11;
   localparam int byte_w = 8;

   // cycles from rden high to rdata valid
   localparam int read_latency = 2;

   // ========================================
   // request address views
   // ========================================

   // command memory holds one entry per 16-byte block
   typedef struct packed {
      logic [19:0] block;
      // byte within the block, unused by the command memory
      logic [3:0] line;
   } req_addr_blocked_s;

   // flat = byte address for download and data memories
   // blocked = block index for the command memory
   typedef union packed {
      logic [mem_addr_w-1:0] flat;
      req_addr_blocked_s blocked;
   } req_addr_u;

endpackage

//--- request_capture.sv
// ini_done and rx_flag are async levels; rack_id/slot_id must be stable before ini_done rises
`timescale 1ns/1ns

module request_capture (
   input  logic clk,
   input  logic reset,
   input  logic ini_done,
   input  logic rx_flag,
   input  logic [mem_bus_pkg::byte_w-1:0] rx_mode,
   input  logic [mem_bus_pkg::mem_addr_w-1:0] rx_addr,
   input  logic [2:0] rack_id,
   input  logic [3:0] slot_id,
   output logic init_pulse,
   output logic req_pulse,
   output logic [mem_bus_pkg::byte_w-1:0] req_mode,
   output mem_bus_pkg::req_addr_u req_addr,
   output logic [mem_bus_pkg::byte_w-1:0] src_addr
);
   import frame_format_pkg::*;
   import mem_bus_pkg::*;

   // bit 0 follows ini_done, bit 1 follows rx_flag
   logic [1:0] ctl_meta;
   logic [1:0] ctl_sync;
   logic [1:0] ctl_prev;
   logic [1:0] ctl_rise;

   // ========================================
   // synchronizers and edge detect
   // ========================================

   // rise seen one cycle after second sync flop
   assign ctl_rise = ctl_sync & ~ctl_prev;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ctl_meta <= '0;
         ctl_sync <= '0;
         ctl_prev <= '0;
         init_pulse <= 1'b0;
         req_pulse <= 1'b0;
      end
      else
      begin
         ctl_meta <= {rx_flag, ini_done};
         ctl_sync <= ctl_meta;
         ctl_prev <= ctl_sync;
         // pulses land 3 cycles after the input rises
         init_pulse <= ctl_rise[0];
         req_pulse <= ctl_rise[1];
      end
   end

   // ========================================
   // latched request fields
   // ========================================

   // held until the next rx_flag edge
   always_ff @(posedge clk)
   begin
      if (ctl_rise[1])
      begin
         req_mode <= rx_mode;
         req_addr.flat <= rx_addr;
      end
      // station address, wraps modulo 256
      if (ctl_rise[0])
      begin
         src_addr <= byte_w'(rack_id) * byte_w'(slots_per_rack)
                     + byte_w'(slots_per_rack) - byte_w'(slot_id);
      end
   end

endmodule

//--- frame_sequencer.sv
// one request per frame; a req_pulse outside wait_request is dropped, memories never stall
`timescale 1ns/1ns

module frame_sequencer (
   input  logic clk,
   input  logic reset,
   input  logic init_pulse,
   input  logic req_pulse,
   input  logic [mem_bus_pkg::byte_w-1:0] req_mode,
   input  mem_bus_pkg::req_addr_u req_addr,
   input  logic [mem_bus_pkg::byte_w-1:0] src_addr,
   input  logic [mem_bus_pkg::byte_w-1:0] ldub_rdata,
   input  logic [mem_bus_pkg::byte_w-1:0] lcucb_rdata,
   input  logic [mem_bus_pkg::byte_w-1:0] lcudb_rdata,
   output logic ldub_rden,
   output logic [mem_bus_pkg::mem_addr_w-1:0] ldub_raddr,
   output logic lcucb_rden,
   output logic [mem_bus_pkg::mem_addr_w-1:0] lcucb_raddr,
   output logic lcudb_rden,
   output logic [mem_bus_pkg::mem_addr_w-1:0] lcudb_raddr,
   output logic wr_strobe,
   output logic [mem_bus_pkg::buf_addr_w-1:0] wr_offset,
   output logic [mem_bus_pkg::byte_w-1:0] wr_byte,
   output logic frame_done
);
   import frame_format_pkg::*;
   import mem_bus_pkg::*;

   logic [st_w-1:0] state;
   logic [1:0] hdr_cnt;
   // reads issued in the current command or data run
   logic [7:0] cnt;
   logic mode_dl;
   // private copies, a mid-frame request must not leak in
   logic [byte_w-1:0] mode_byte;
   logic [mem_addr_w-1:0] base_addr;
   logic [mem_addr_w-1:0] rd_addr;
   logic [mem_addr_w-1:0] data_start;
   // read tags, last stage lines up with rdata
   logic [read_latency-1:0] tag_valid;
   logic [buf_addr_w-1:0] tag_off [read_latency];
   logic issue_cmd;
   logic issue_data;
   logic issue;
   logic type_go;
   logic [buf_addr_w-1:0] issue_off;
   logic ret_valid;
   logic [buf_addr_w-1:0] ret_off;
   logic [byte_w-1:0] ret_byte;
   logic [byte_w-1:0] hdr_byte;

   // ========================================
   // read issue
   // ========================================

   // type waits for the command reads to drain
   assign type_go = (state == st_type) && (tag_valid == '0);
   assign issue_cmd = (state == st_mode) || (state == st_command);
   assign issue_data = type_go || ((state == st_data) && (cnt < data_len));
   assign issue = issue_cmd || issue_data;
   assign issue_off = issue_cmd ? buf_addr_w'(offs_cmd) + buf_addr_w'(cnt)
                                : buf_addr_w'(offs_data) + buf_addr_w'(cnt);
   assign data_start = mode_dl ? base_addr + mem_addr_w'(download_data_skip) : base_addr;

   // download mode reads everything from ldub
   assign ldub_rden = issue && mode_dl;
   assign lcucb_rden = issue_cmd && !mode_dl;
   assign lcudb_rden = issue_data && !mode_dl;
   assign ldub_raddr = rd_addr;
   assign lcucb_raddr = rd_addr;
   assign lcudb_raddr = rd_addr;

   // ========================================
   // latency pipeline
   // ========================================

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         tag_valid <= '0;
      else
         tag_valid <= {tag_valid[read_latency-2:0], issue};
   end

   always_ff @(posedge clk)
   begin
      tag_off[0] <= issue_off;
      for (int i = 1; i < read_latency; i++)
         tag_off[i] <= tag_off[i-1];
   end

   assign ret_valid = tag_valid[read_latency-1];
   assign ret_off = tag_off[read_latency-1];
   // source follows from mode and offset, no need to tag it
   assign ret_byte = mode_dl ? ldub_rdata
                   : (ret_off >= buf_addr_w'(offs_data)) ? lcudb_rdata : lcucb_rdata;
   assign frame_done = ret_valid && (ret_off == buf_addr_w'(frame_len - 1));

   // ========================================
   // write path
   // ========================================

   always_comb
   begin
      case (hdr_cnt)
         2'd0: hdr_byte = dest_addr_byte;
         2'd1: hdr_byte = src_addr;
         default: hdr_byte = func_code_byte;
      endcase
   end

   // returned bytes win, constants never overlap with them
   always_comb
   begin
      wr_strobe = 1'b0;
      wr_offset = '0;
      wr_byte = '0;
      if (ret_valid)
      begin
         wr_strobe = 1'b1;
         wr_offset = ret_off;
         wr_byte = ret_byte;
      end
      else if (state == st_header)
      begin
         // header offset equals hdr_cnt
         wr_strobe = 1'b1;
         wr_offset = buf_addr_w'(hdr_cnt);
         wr_byte = hdr_byte;
      end
      else if (state == st_mode)
      begin
         wr_strobe = 1'b1;
         wr_offset = buf_addr_w'(offs_mode);
         wr_byte = mode_byte;
      end
      else if (type_go)
      begin
         wr_strobe = 1'b1;
         wr_offset = buf_addr_w'(offs_type);
         wr_byte = type_byte;
      end
   end

   // ========================================
   // state machine
   // ========================================

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= st_idle;
         hdr_cnt <= '0;
         cnt <= '0;
         mode_dl <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
               if (init_pulse)
               begin
                  state <= st_header;
                  hdr_cnt <= '0;
               end
            st_header:
            begin
               hdr_cnt <= hdr_cnt + 2'd1;
               if (hdr_cnt == 2'd2)
                  state <= st_wait_request;
            end
            st_wait_request:
               if (req_pulse)
               begin
                  state <= st_mode;
                  cnt <= '0;
                  mode_dl <= (req_mode == mode_download);
               end
            // first command read goes out with the mode byte
            st_mode:
            begin
               cnt <= 8'd1;
               state <= st_command;
            end
            st_command:
               if (cnt == 8'(cmd_len - 1))
               begin
                  cnt <= '0;
                  state <= st_type;
               end
               else
                  cnt <= cnt + 8'd1;
            st_type:
               if (type_go)
               begin
                  cnt <= 8'd1;
                  state <= st_data;
               end
            st_data:
            begin
               if (cnt < data_len)
                  cnt <= cnt + 8'd1;
               if (frame_done)
                  state <= st_wait_request;
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   // request copies and read address counter
   always_ff @(posedge clk)
   begin
      if ((state == st_wait_request) && req_pulse)
      begin
         mode_byte <= req_mode;
         base_addr <= req_addr.flat;
         rd_addr <= (req_mode == mode_download) ? req_addr.flat
                                                 : mem_addr_w'(req_addr.blocked.block);
      end
      else if (issue)
      begin
         // last command read, jump to the data start
         if ((state == st_command) && (cnt == 8'(cmd_len - 1)))
            rd_addr <= data_start;
         else
            rd_addr <= rd_addr + 1'b1;
      end
   end

endmodule

//--- tx_buffer_writer.sv
// length is the highest offset written since the last start plus one, no frame restarts midway
`timescale 1ns/1ns

module tx_buffer_writer (
   input  logic clk,
   input  logic reset,
   input  logic wr_strobe,
   input  logic [mem_bus_pkg::buf_addr_w-1:0] wr_offset,
   input  logic [mem_bus_pkg::byte_w-1:0] wr_byte,
   input  logic frame_done,
   output logic tx_buf_wren,
   output logic [mem_bus_pkg::buf_addr_w-1:0] tx_buf_waddr,
   output logic [mem_bus_pkg::byte_w-1:0] tx_buf_wdata,
   output logic tx_start,
   output logic [mem_bus_pkg::buf_addr_w-1:0] tx_data_len
);
   import mem_bus_pkg::*;

   // highest buffer offset written since the last start
   logic [buf_addr_w-1:0] hi_off;
   logic [buf_addr_w-1:0] next_hi;
   // frame_done lined up with the registered write
   logic done_d;

   // ========================================
   // frame length tracking
   // ========================================

   // includes the write leaving the register this cycle
   assign next_hi = (tx_buf_wren && (tx_buf_waddr > hi_off)) ? tx_buf_waddr : hi_off;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         tx_buf_wren <= 1'b0;
         done_d <= 1'b0;
         tx_start <= 1'b0;
         tx_data_len <= '0;
         hi_off <= '0;
      end
      else
      begin
         tx_buf_wren <= wr_strobe;
         done_d <= frame_done;
         // start lands one cycle after the last buffer write
         tx_start <= done_d;
         if (done_d)
         begin
            tx_data_len <= next_hi + 1'b1;
            hi_off <= '0;
         end
         else
            hi_off <= next_hi;
      end
   end

   // ========================================
   // write port register
   // ========================================

   // address and data only matter with tx_buf_wren
   always_ff @(posedge clk)
   begin
      tx_buf_waddr <= wr_offset;
      tx_buf_wdata <= wr_byte;
   end

endmodule

//--- tx_frame_top.sv
// card-level frame assembler; memories are external with fixed latency, no serial transmitter here
`timescale 1ns/1ns

module tx_frame_top (
   input  logic clk,
   input  logic reset,
   input  logic ini_done,
   input  logic rx_flag,
   input  logic [mem_bus_pkg::byte_w-1:0] rx_mode,
   input  logic [mem_bus_pkg::mem_addr_w-1:0] rx_addr,
   input  logic [2:0] rack_id,
   input  logic [3:0] slot_id,
   input  logic [mem_bus_pkg::byte_w-1:0] ldub_rdata,
   input  logic [mem_bus_pkg::byte_w-1:0] lcucb_rdata,
   input  logic [mem_bus_pkg::byte_w-1:0] lcudb_rdata,
   output logic ldub_rden,
   output logic [mem_bus_pkg::mem_addr_w-1:0] ldub_raddr,
   output logic lcucb_rden,
   output logic [mem_bus_pkg::mem_addr_w-1:0] lcucb_raddr,
   output logic lcudb_rden,
   output logic [mem_bus_pkg::mem_addr_w-1:0] lcudb_raddr,
   output logic tx_buf_wren,
   output logic [mem_bus_pkg::buf_addr_w-1:0] tx_buf_waddr,
   output logic [mem_bus_pkg::byte_w-1:0] tx_buf_wdata,
   output logic tx_start,
   output logic [mem_bus_pkg::buf_addr_w-1:0] tx_data_len
);
   import mem_bus_pkg::*;

   // capture to sequencer
   logic init_pulse;
   logic req_pulse;
   logic [byte_w-1:0] req_mode;
   req_addr_u req_addr;
   logic [byte_w-1:0] src_addr;
   // sequencer to buffer writer
   logic wr_strobe;
   logic [buf_addr_w-1:0] wr_offset;
   logic [byte_w-1:0] wr_byte;
   logic frame_done;

   // ========================================
   // input side
   // ========================================

   request_capture u_request_capture (
      .clk(clk),
      .reset(reset),
      .ini_done(ini_done),
      .rx_flag(rx_flag),
      .rx_mode(rx_mode),
      .rx_addr(rx_addr),
      .rack_id(rack_id),
      .slot_id(slot_id),
      .init_pulse(init_pulse),
      .req_pulse(req_pulse),
      .req_mode(req_mode),
      .req_addr(req_addr),
      .src_addr(src_addr)
   );

   // ========================================
   // sequencer and memory reads
   // ========================================

   frame_sequencer u_frame_sequencer (
      .clk(clk),
      .reset(reset),
      .init_pulse(init_pulse),
      .req_pulse(req_pulse),
      .req_mode(req_mode),
      .req_addr(req_addr),
      .src_addr(src_addr),
      .ldub_rdata(ldub_rdata),
      .lcucb_rdata(lcucb_rdata),
      .lcudb_rdata(lcudb_rdata),
      .ldub_rden(ldub_rden),
      .ldub_raddr(ldub_raddr),
      .lcucb_rden(lcucb_rden),
      .lcucb_raddr(lcucb_raddr),
      .lcudb_rden(lcudb_rden),
      .lcudb_raddr(lcudb_raddr),
      .wr_strobe(wr_strobe),
      .wr_offset(wr_offset),
      .wr_byte(wr_byte),
      .frame_done(frame_done)
   );

   // ========================================
   // output side
   // ========================================

   tx_buffer_writer u_tx_buffer_writer (
      .clk(clk),
      .reset(reset),
      .wr_strobe(wr_strobe),
      .wr_offset(wr_offset),
      .wr_byte(wr_byte),
      .frame_done(frame_done),
      .tx_buf_wren(tx_buf_wren),
      .tx_buf_waddr(tx_buf_waddr),
      .tx_buf_wdata(tx_buf_wdata),
      .tx_start(tx_start),
      .tx_data_len(tx_data_len)
   );

endmodule

//--- tb_source_mem.sv
// read-only byte memory, contents fixed by address; output is zero after a cycle with no read
`timescale 1ns/1ns

module tb_source_mem #(
   parameter logic [7:0] tag = 8'h00
) (
   input  logic clk,
   input  logic rden,
   input  logic [mem_bus_pkg::mem_addr_w-1:0] raddr,
   output logic [mem_bus_pkg::byte_w-1:0] rdata
);
   import mem_bus_pkg::*;

   // one stage per cycle of read latency
   logic [byte_w-1:0] pipe [read_latency];

   // ========================================
   // contents
   // ========================================

   // every address byte feeds the pattern, tag keeps the three memories apart
   function automatic logic [byte_w-1:0] fill_byte(input logic [mem_addr_w-1:0] a);
      return a[7:0] ^ a[15:8] ^ {a[19:16], a[23:20]} ^ tag;
   endfunction

   // ========================================
   // read pipeline
   // ========================================

   always @(posedge clk)
   begin
      pipe[0] <= rden ? fill_byte(raddr) : '0;
      for (int i = 1; i < read_latency; i++)
         pipe[i] <= pipe[i-1];
   end

   // valid exactly read_latency cycles after rden
   assign rdata = pipe[read_latency-1];

endmodule

//--- tx_frame_checker.sv
// strobe and pulse rules only, byte contents are not looked at here
`timescale 1ns/1ns

module tx_frame_checker (
   input logic clk,
   input logic reset,
   input logic tx_start,
   input logic tx_buf_wren,
   input logic ldub_rden,
   input logic lcucb_rden,
   input logic lcudb_rden
);

   // failed assertions so far
   int fail_count = 0;

   // ========================================
   // pulse and strobe rules
   // ========================================

   // start pulse never stretches
   start_one_cycle: assert property (@(posedge clk) disable iff (reset) tx_start |=> !tx_start)
      else
      begin
         fail_count++;
         $error("tx_start high for more than one cycle");
      end

   // only one memory read at a time
   one_rden: assert property (@(posedge clk) disable iff (reset)
                              $onehot0({ldub_rden, lcucb_rden, lcudb_rden}))
      else
      begin
         fail_count++;
         $error("more than one rden strobe high");
      end

   // buffer and transmitter stay quiet in reset
   quiet_in_reset: assert property (@(posedge clk) reset |-> !tx_buf_wren && !tx_start)
      else
      begin
         fail_count++;
         $error("tx_buf_wren or tx_start high during reset");
      end

endmodule

// writer side, no memory strobes here
bind tx_buffer_writer tx_frame_checker u_writer_checker (
   .clk(clk),
   .reset(reset),
   .tx_start(tx_start),
   .tx_buf_wren(tx_buf_wren),
   .ldub_rden(1'b0),
   .lcucb_rden(1'b0),
   .lcudb_rden(1'b0)
);

// sequencer side, only the read strobes
bind frame_sequencer tx_frame_checker u_sequencer_checker (
   .clk(clk),
   .reset(reset),
   .tx_start(1'b0),
   .tx_buf_wren(1'b0),
   .ldub_rden(ldub_rden),
   .lcucb_rden(lcucb_rden),
   .lcudb_rden(lcudb_rden)
);

//--- tb_tx_frame.sv
// one init then 40 random requests, one extra request dropped mid-frame; modes 01h/03h non-download
`timescale 1ns/1ns

module tb_tx_frame;
   import frame_format_pkg::*;
   import mem_bus_pkg::*;

   localparam int num_requests = 40;
   localparam int mid_frame_index = 17;
   // per request budget, plus reset, init and margin
   localparam int watchdog_cycles = num_requests * 400 + 2000;
   localparam logic [7:0] tag_ldub = 8'h5A;
   localparam logic [7:0] tag_lcucb = 8'hC3;
   localparam logic [7:0] tag_lcudb = 8'h3C;

   logic clk;
   logic reset;
   logic ini_done;
   logic rx_flag;
   logic [byte_w-1:0] rx_mode;
   logic [mem_addr_w-1:0] rx_addr;
   logic [2:0] rack_id;
   logic [3:0] slot_id;
   logic [byte_w-1:0] ldub_rdata;
   logic [byte_w-1:0] lcucb_rdata;
   logic [byte_w-1:0] lcudb_rdata;
   logic ldub_rden;
   logic lcucb_rden;
   logic lcudb_rden;
   logic [mem_addr_w-1:0] ldub_raddr;
   logic [mem_addr_w-1:0] lcucb_raddr;
   logic [mem_addr_w-1:0] lcudb_raddr;
   logic tx_buf_wren;
   logic [buf_addr_w-1:0] tx_buf_waddr;
   logic [byte_w-1:0] tx_buf_wdata;
   logic tx_start;
   logic [buf_addr_w-1:0] tx_data_len;

   // buffer model and writes since the last tx_start
   logic [byte_w-1:0] buf_mem [2**buf_addr_w];
   int wr_count;
   int unsigned seed_val;
   // request the current frame must follow
   logic [byte_w-1:0] exp_mode;
   logic [mem_addr_w-1:0] exp_addr;

   // ========================================
   // DUT and memories
   // ========================================

   tx_frame_top u_tx_frame_top (
      .clk(clk),
      .reset(reset),
      .ini_done(ini_done),
      .rx_flag(rx_flag),
      .rx_mode(rx_mode),
      .rx_addr(rx_addr),
      .rack_id(rack_id),
      .slot_id(slot_id),
      .ldub_rdata(ldub_rdata),
      .lcucb_rdata(lcucb_rdata),
      .lcudb_rdata(lcudb_rdata),
      .ldub_rden(ldub_rden),
      .ldub_raddr(ldub_raddr),
      .lcucb_rden(lcucb_rden),
      .lcucb_raddr(lcucb_raddr),
      .lcudb_rden(lcudb_rden),
      .lcudb_raddr(lcudb_raddr),
      .tx_buf_wren(tx_buf_wren),
      .tx_buf_waddr(tx_buf_waddr),
      .tx_buf_wdata(tx_buf_wdata),
      .tx_start(tx_start),
      .tx_data_len(tx_data_len)
   );

   tb_source_mem #(.tag(tag_ldub)) u_ldub_mem (
      .clk(clk),
      .rden(ldub_rden),
      .raddr(ldub_raddr),
      .rdata(ldub_rdata)
   );

   tb_source_mem #(.tag(tag_lcucb)) u_lcucb_mem (
      .clk(clk),
      .rden(lcucb_rden),
      .raddr(lcucb_raddr),
      .rdata(lcucb_rdata)
   );

   tb_source_mem #(.tag(tag_lcudb)) u_lcudb_mem (
      .clk(clk),
      .rden(lcudb_rden),
      .raddr(lcudb_raddr),
      .rdata(lcudb_rdata)
   );

   // ========================================
   // models
   // ========================================

   // same fill rule as the memories, tag picks the memory
   function automatic logic [7:0] model_byte(input logic [7:0] tag, input logic [23:0] a);
      return a[7:0] ^ a[15:8] ^ {a[19:16], a[23:20]} ^ tag;
   endfunction

   // rack * 14 + 14 - slot, wraps to 8 bits
   function automatic logic [7:0] station_addr(input logic [2:0] rack, input logic [3:0] slot);
      int s;
      s = int'(rack) * 14 + 14 - int'(slot);
      return 8'(s);
   endfunction

   always @(posedge clk)
   begin
      if (tx_buf_wren)
         buf_mem[tx_buf_waddr] <= tx_buf_wdata;
      if (reset || tx_start)
         wr_count <= 0;
      else if (tx_buf_wren)
         wr_count <= wr_count + 1;
   end

   // ========================================
   // checks and helpers
   // ========================================

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   // raise rx_flag long enough for the synchronizer, fields held
   task automatic issue_request(input logic [7:0] mode, input logic [23:0] addr);
      @(posedge clk);
      rx_mode <= mode;
      rx_addr <= addr;
      rx_flag <= 1'b1;
      repeat (4) @(posedge clk);
      rx_flag <= 1'b0;
   endtask

   task automatic wait_write(input logic [buf_addr_w-1:0] off);
      do
         @(negedge clk);
      while (!(tx_buf_wren === 1'b1 && tx_buf_waddr == off));
      // buffer model takes it at the next edge
      @(negedge clk);
   endtask

   task automatic check_frame(input bit first);
      logic dl;
      logic [7:0] cmd_tag;
      logic [7:0] data_tag;
      logic [23:0] cmd_base;
      logic [23:0] data_base;
      dl = (exp_mode == mode_download);
      cmd_tag = dl ? tag_ldub : tag_lcucb;
      data_tag = dl ? tag_ldub : tag_lcudb;
      // command memory is addressed per 16-byte block
      cmd_base = dl ? exp_addr : {4'h0, exp_addr[23:4]};
      data_base = dl ? exp_addr + 24'(download_data_skip) : exp_addr;
      check_value("tx_data_len", 32'(tx_data_len), frame_len);
      // first frame also counts the header writes
      check_value("write count", wr_count, first ? frame_len : frame_len - 3);
      check_value("buf[3]", 32'(buf_mem[offs_mode]), 32'(exp_mode));
      check_value("buf[9]", 32'(buf_mem[offs_type]), 32'(type_byte));
      for (int i = 0; i < cmd_len; i++)
         check_value($sformatf("buf[%0d]", offs_cmd + i), 32'(buf_mem[offs_cmd + i]),
                     32'(model_byte(cmd_tag, cmd_base + 24'(i))));
      for (int i = 0; i < data_len; i++)
         check_value($sformatf("buf[%0d]", offs_data + i), 32'(buf_mem[offs_data + i]),
                     32'(model_byte(data_tag, data_base + 24'(i))));
   endtask

   // ========================================
   // clock, watchdog, assertion monitor
   // ========================================

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: no tx_start arrived within %0d cycles", watchdog_cycles);
      $display("ERRORS FOUND");
      $fatal(1);
   end

   always @(negedge clk)
   begin
      if (u_tx_frame_top.u_tx_buffer_writer.u_writer_checker.fail_count
          + u_tx_frame_top.u_frame_sequencer.u_sequencer_checker.fail_count != 0)
      begin
         $display("a bound checker assertion failed");
         $display("ERRORS FOUND");
         $fatal(1);
      end
   end

   // ========================================
   // stimulus
   // ========================================

   initial
   begin
      int unsigned sel;
      logic [7:0] mode;
      logic [23:0] addr;
      reset = 1'b1;
      ini_done = 1'b0;
      rx_flag = 1'b0;
      rx_mode = '0;
      rx_addr = '0;
      rack_id = '0;
      slot_id = '0;
      seed_val = $urandom(78);
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      rack_id <= 3'($urandom_range(7, 0));
      slot_id <= 4'($urandom_range(15, 0));
      @(posedge clk);
      ini_done <= 1'b1;
      // header lands at offsets 0..2
      wait_write(11'd2);
      check_value("buf[0]", 32'(buf_mem[0]), 32'(dest_addr_byte));
      check_value("buf[1]", 32'(buf_mem[1]), 32'(station_addr(rack_id, slot_id)));
      check_value("buf[2]", 32'(buf_mem[2]), 32'(func_code_byte));
      for (int n = 0; n < num_requests; n++)
      begin
         sel = $urandom_range(2, 0);
         mode = (sel == 0) ? mode_download : ((sel == 1) ? 8'h01 : 8'h03);
         addr = 24'($urandom);
         exp_mode = mode;
         exp_addr = addr;
         issue_request(mode, addr);
         // extra request in the data phase, must be dropped
         if (n == mid_frame_index)
         begin
            wait_write(11'd40);
            issue_request((mode == mode_download) ? 8'h01 : mode_download, ~addr);
         end
         do
            @(negedge clk);
         while (tx_start !== 1'b1);
         check_frame(n == 0);
      end
      if (u_tx_frame_top.u_tx_buffer_writer.u_writer_checker.fail_count
          + u_tx_frame_top.u_frame_sequencer.u_sequencer_checker.fail_count != 0)
      begin
         $display("ERRORS FOUND");
         $fatal(1);
      end
      else
      begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

//--- files.f
frame_format_pkg.sv
mem_bus_pkg.sv
request_capture.sv
frame_sequencer.sv
tx_buffer_writer.sv
tx_frame_top.sv
tb_source_mem.sv
tx_frame_checker.sv
tb_tx_frame.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_tx_frame
FILELIST = files.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
